/* design/axi_reg_pkg.sv */
// AXI write register slice shared widths, payload structs and buffer mode codes
package axi_reg_pkg;

    // bus widths
    localparam int ID_WIDTH   = 8;
    localparam int ADDR_WIDTH = 32;
    localparam int DATA_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;

    // AXI burst encoding
    typedef enum logic [1:0] {
        FIXED = 2'b00,
        INCR  = 2'b01,
        WRAP  = 2'b10
    } burst_e;

    // write response codes
    typedef enum logic [1:0] {
        OKAY   = 2'b00,
        EXOKAY = 2'b01,
        SLVERR = 2'b10,
        DECERR = 2'b11
    } resp_e;

    // write address beat, 56 bits
    typedef struct packed {
        logic [ID_WIDTH-1:0]   id;
        logic [ADDR_WIDTH-1:0] addr;
        logic [7:0]            len;
        logic [2:0]            size;
        burst_e                burst;
        logic [2:0]            prot;
    } aw_t;

    // write data beat, 37 bits
    typedef struct packed {
        logic [DATA_WIDTH-1:0] data;
        logic [STRB_WIDTH-1:0] strb;
        logic                  last;
    } w_t;

    // write response beat, 10 bits
    typedef struct packed {
        logic [ID_WIDTH-1:0] id;
        resp_e               resp;
    } b_t;

    // per-channel buffer choice
    typedef enum logic {
        REG_SIMPLE = 1'b0,
        REG_SKID   = 1'b1
    } reg_mode_e;

endpackage

/* design/axi_skid_buffer.sv */
// skid buffer for one AXI channel, output plus temp register, no bubble cycles
`timescale 1ns/1ns

module axi_skid_buffer
    import axi_reg_pkg::*;
#(
    parameter type T = w_t
) (
    input  logic clk,
    input  logic rstn,
    input  T     in_data,
    input  logic in_valid,
    output logic in_ready,
    output T     out_data,
    output logic out_valid,
    input  logic out_ready
);

    T     out_reg;
    T     temp_reg;
    logic out_valid_reg;
    logic out_valid_next;
    logic temp_valid_reg;
    logic temp_valid_next;
    logic in_ready_reg;
    logic in_ready_early;

    // steering for this cycle
    logic store_in_to_out;
    logic store_in_to_temp;
    logic store_temp_to_out;

    assign in_ready  = in_ready_reg;
    assign out_data  = out_reg;
    assign out_valid = out_valid_reg;

    // stay ready while downstream drains or the temp slot cannot fill next edge
    assign in_ready_early = out_ready | (~temp_valid_reg & (~out_valid_reg | ~in_valid));

    always_comb begin
        out_valid_next    = out_valid_reg;
        temp_valid_next   = temp_valid_reg;
        store_in_to_out   = 1'b0;
        store_in_to_temp  = 1'b0;
        store_temp_to_out = 1'b0;

        if (in_ready_reg) begin
            if (out_ready | ~out_valid_reg) begin
                // output slot free or draining
                out_valid_next  = in_valid;
                store_in_to_out = 1'b1;
            end else begin
                // output stalled, catch the beat in temp
                temp_valid_next  = in_valid;
                store_in_to_temp = 1'b1;
            end
        end else if (out_ready) begin
            // input closed, move the held beat forward
            out_valid_next    = temp_valid_reg;
            temp_valid_next   = 1'b0;
            store_temp_to_out = 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            in_ready_reg   <= 1'b0;
            out_valid_reg  <= 1'b0;
            temp_valid_reg <= 1'b0;
        end else begin
            in_ready_reg   <= in_ready_early;
            out_valid_reg  <= out_valid_next;
            temp_valid_reg <= temp_valid_next;
        end
    end

    // payload path
    always_ff @(posedge clk) begin
        if (store_in_to_out) begin
            out_reg <= in_data;
        end else if (store_temp_to_out) begin
            out_reg <= temp_reg;
        end

        if (store_in_to_temp) begin
            temp_reg <= in_data;
        end
    end

endmodule

/* design/axi_simple_buffer.sv */
// simple register stage for one AXI channel, one bubble after each transfer
`timescale 1ns/1ns

module axi_simple_buffer
    import axi_reg_pkg::*;
#(
    parameter type T = aw_t
) (
    input  logic clk,
    input  logic rstn,
    input  T     in_data,
    input  logic in_valid,
    output logic in_ready,
    output T     out_data,
    output logic out_valid,
    input  logic out_ready
);

    T     out_reg;
    logic out_valid_reg;
    logic out_valid_next;
    logic in_ready_reg;
    logic store_in;

    assign in_ready  = in_ready_reg;
    assign out_data  = out_reg;
    assign out_valid = out_valid_reg;

    always_comb begin
        out_valid_next = out_valid_reg;
        store_in       = 1'b0;

        if (in_ready_reg) begin
            // output is empty whenever ready was granted
            out_valid_next = in_valid;
            store_in       = 1'b1;
        end else if (out_ready) begin
            out_valid_next = 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            in_ready_reg  <= 1'b0;
            out_valid_reg <= 1'b0;
        end else begin
            // open the input only once the output will sit empty
            in_ready_reg  <= ~out_valid_next;
            out_valid_reg <= out_valid_next;
        end
    end

    always_ff @(posedge clk) begin
        if (store_in) begin
            out_reg <= in_data;
        end
    end

endmodule

/* design/axi_register_wr.sv */
// AXI4 write register slice, one selectable buffer on each of AW, W and B
`timescale 1ns/1ns

module axi_register_wr
    import axi_reg_pkg::*;
#(
    parameter reg_mode_e AW_REG_TYPE = REG_SIMPLE,
    parameter reg_mode_e W_REG_TYPE  = REG_SKID,
    parameter reg_mode_e B_REG_TYPE  = REG_SIMPLE
) (
    input  logic clk,
    input  logic rstn,

    // slave side, from the upstream master
    input  aw_t  s_aw,
    input  logic s_aw_valid,
    output logic s_aw_ready,
    input  w_t   s_w,
    input  logic s_w_valid,
    output logic s_w_ready,
    output b_t   s_b,
    output logic s_b_valid,
    input  logic s_b_ready,

    // master side, toward the downstream slave
    output aw_t  m_aw,
    output logic m_aw_valid,
    input  logic m_aw_ready,
    output w_t   m_w,
    output logic m_w_valid,
    input  logic m_w_ready,
    input  b_t   m_b,
    input  logic m_b_valid,
    output logic m_b_ready
);

    generate
        // write address
        if (AW_REG_TYPE == REG_SKID) begin : g_aw_skid
            axi_skid_buffer #(.T(aw_t)) i_aw_buf (
                .clk(clk), .rstn(rstn),
                .in_data(s_aw), .in_valid(s_aw_valid), .in_ready(s_aw_ready),
                .out_data(m_aw), .out_valid(m_aw_valid), .out_ready(m_aw_ready)
            );
        end else begin : g_aw_simple
            axi_simple_buffer #(.T(aw_t)) i_aw_buf (
                .clk(clk), .rstn(rstn),
                .in_data(s_aw), .in_valid(s_aw_valid), .in_ready(s_aw_ready),
                .out_data(m_aw), .out_valid(m_aw_valid), .out_ready(m_aw_ready)
            );
        end

        // write data
        if (W_REG_TYPE == REG_SKID) begin : g_w_skid
            axi_skid_buffer #(.T(w_t)) i_w_buf (
                .clk(clk), .rstn(rstn),
                .in_data(s_w), .in_valid(s_w_valid), .in_ready(s_w_ready),
                .out_data(m_w), .out_valid(m_w_valid), .out_ready(m_w_ready)
            );
        end else begin : g_w_simple
            axi_simple_buffer #(.T(w_t)) i_w_buf (
                .clk(clk), .rstn(rstn),
                .in_data(s_w), .in_valid(s_w_valid), .in_ready(s_w_ready),
                .out_data(m_w), .out_valid(m_w_valid), .out_ready(m_w_ready)
            );
        end

        // write response runs back from master port to slave port
        if (B_REG_TYPE == REG_SKID) begin : g_b_skid
            axi_skid_buffer #(.T(b_t)) i_b_buf (
                .clk(clk), .rstn(rstn),
                .in_data(m_b), .in_valid(m_b_valid), .in_ready(m_b_ready),
                .out_data(s_b), .out_valid(s_b_valid), .out_ready(s_b_ready)
            );
        end else begin : g_b_simple
            axi_simple_buffer #(.T(b_t)) i_b_buf (
                .clk(clk), .rstn(rstn),
                .in_data(m_b), .in_valid(m_b_valid), .in_ready(m_b_ready),
                .out_data(s_b), .out_valid(s_b_valid), .out_ready(s_b_ready)
            );
        end
    endgenerate

endmodule

/* tb/axi_register_wr_chk.sv */
// protocol checker for the AXI write register slice, bound into the top level
`timescale 1ns/1ns

module axi_register_wr_chk
    import axi_reg_pkg::*;
(
    input logic clk,
    input logic rstn,
    input aw_t  m_aw,
    input logic m_aw_valid,
    input logic m_aw_ready,
    input w_t   m_w,
    input logic m_w_valid,
    input logic m_w_ready,
    input logic s_aw_valid,
    input logic s_aw_ready,
    input logic s_b_valid
);

    int unsigned fail_count = 0;

    // a reset edge clears every outgoing valid
    reset_valids_low: assert property (@(posedge clk)
        !rstn |=> (!m_aw_valid && !m_w_valid && !s_b_valid))
    else begin
        $error("outgoing valid high after a reset edge");
        fail_count++;
    end

    // simple buffer closes its input right after each accept
    aw_bubble: assert property (@(posedge clk) disable iff (!rstn)
        (s_aw_valid && s_aw_ready) |=> !s_aw_ready)
    else begin
        $error("AW accepted in back-to-back cycles");
        fail_count++;
    end

    aw_hold: assert property (@(posedge clk) disable iff (!rstn)
        (m_aw_valid && !m_aw_ready) |=> (m_aw_valid && $stable(m_aw)))
    else begin
        $error("m_aw changed or dropped while stalled");
        fail_count++;
    end

    w_hold: assert property (@(posedge clk) disable iff (!rstn)
        (m_w_valid && !m_w_ready) |=> (m_w_valid && $stable(m_w)))
    else begin
        $error("m_w changed or dropped while stalled");
        fail_count++;
    end

endmodule

/* tb/tb_axi_register_wr.sv */
// testbench for the AXI write register slice, golden file stimulus with random back-pressure
`timescale 1ns/1ns

module tb_axi_register_wr
    import axi_reg_pkg::*;
();

    logic clk = 1'b0;
    logic rstn = 1'b0;
    aw_t  s_aw = '0;
    logic s_aw_valid = 1'b0;
    logic s_aw_ready;
    w_t   s_w = '0;
    logic s_w_valid = 1'b0;
    logic s_w_ready;
    b_t   s_b;
    logic s_b_valid;
    logic s_b_ready = 1'b0;
    aw_t  m_aw;
    logic m_aw_valid;
    logic m_aw_ready = 1'b0;
    w_t   m_w;
    logic m_w_valid;
    logic m_w_ready = 1'b0;
    b_t   m_b = '0;
    logic m_b_valid = 1'b0;
    logic m_b_ready;

    aw_t aw_exp[$];
    w_t  w_exp[$];
    b_t  b_exp[$];

    // stimulus and checking progress
    int aw_sent = 0;
    int w_sent = 0;
    int b_sent = 0;
    int aw_got = 0;
    int w_got = 0;
    int b_got = 0;
    int lasts_seen = 0;
    int cycle = 0;
    int cycle_limit = 1000;
    int w_close_at = 0;
    int w_phase_beats = 0;
    logic w_hold = 1'b0;
    logic aw_acc_prev = 1'b0;
    logic rstn_q = 1'b0;
    logic [31:0] lcg_state = 32'd28400;

    axi_register_wr i_axi_register_wr (.*);

    bind axi_register_wr axi_register_wr_chk i_chk (
        .clk(clk),
        .rstn(rstn),
        .m_aw(m_aw),
        .m_aw_valid(m_aw_valid),
        .m_aw_ready(m_aw_ready),
        .m_w(m_w),
        .m_w_valid(m_w_valid),
        .m_w_ready(m_w_ready),
        .s_aw_valid(s_aw_valid),
        .s_aw_ready(s_aw_ready),
        .s_b_valid(s_b_valid)
    );

    always #4 clk = ~clk;

    // roughly two ready cycles out of three
    function automatic logic ready_draw();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return (lcg_state[23:16] % 8'd3) != 8'd0;
    endfunction

    task automatic stop_with_failure(input string why);
        $display("%s", why);
        $display("Simulation FAILED");
        $fatal(1, "run stopped on first error");
    endtask

    task automatic compare_aw(input string name, input aw_t exp, input aw_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("error %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_w(input string name, input w_t exp, input w_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("error %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_b(input string name, input b_t exp, input b_t act);
        if (act !== exp) begin
            stop_with_failure($sformatf("error %s expected %h actual %h", name, exp, act));
        end
    endtask

    task automatic compare_bit(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            stop_with_failure($sformatf("error %s expected %b actual %b", name, exp, act));
        end
    endtask

    task automatic load_golden();
        int fd;
        int code;
        string line;
        string kind;
        logic [31:0] f0, f1, f2, f3, f4, f5;
        aw_t aw;
        w_t w;
        b_t b;
        fd = $fopen("tb/axi_register_wr_golden.txt", "r");
        if (fd == 0) begin
            stop_with_failure("could not open the golden file tb/axi_register_wr_golden.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            kind = "";
            code = $fgets(line, fd);
            code = $sscanf(line, "%s %h %h %h %h %h %h", kind, f0, f1, f2, f3, f4, f5);
            if (kind == "aw") begin
                aw.id    = f0[7:0];
                aw.addr  = f1;
                aw.len   = f2[7:0];
                aw.size  = f3[2:0];
                aw.burst = burst_e'(f4[1:0]);
                aw.prot  = f5[2:0];
                aw_exp.push_back(aw);
            end else if (kind == "w") begin
                w.data = f0;
                w.strb = f1[3:0];
                w.last = f2[0];
                w_exp.push_back(w);
            end else if (kind == "b") begin
                b.id   = f0[7:0];
                b.resp = resp_e'(f1[1:0]);
                b_exp.push_back(b);
            end
        end
        $fclose(fd);
    endtask

    // sources on the slave side, responder and readies on the master side
    always @(posedge clk) begin
        if (rstn) begin
            if (!s_aw_valid || s_aw_ready) begin
                if (aw_sent < aw_exp.size()) begin
                    s_aw       <= aw_exp[aw_sent];
                    s_aw_valid <= 1'b1;
                    aw_sent    <= aw_sent + 1;
                end else begin
                    s_aw_valid <= 1'b0;
                end
            end
            if (!s_w_valid || s_w_ready) begin
                if (w_sent < w_exp.size()) begin
                    s_w       <= w_exp[w_sent];
                    s_w_valid <= 1'b1;
                    w_sent    <= w_sent + 1;
                end else begin
                    s_w_valid <= 1'b0;
                end
            end
            // a response goes out only after its burst's last beat
            if (!m_b_valid || m_b_ready) begin
                if (b_sent < lasts_seen && b_sent < b_exp.size()) begin
                    m_b       <= b_exp[b_sent];
                    m_b_valid <= 1'b1;
                    b_sent    <= b_sent + 1;
                end else begin
                    m_b_valid <= 1'b0;
                end
            end
            // closing phase keeps the W sink always ready
            if (w_hold || w_sent >= w_close_at) begin
                w_hold    <= 1'b1;
                m_w_ready <= 1'b1;
            end else begin
                m_w_ready <= ready_draw();
            end
            m_aw_ready <= ready_draw();
            s_b_ready  <= ready_draw();
        end
    end

    // monitors and checks
    always @(posedge clk) begin
        cycle  <= cycle + 1;
        rstn_q <= rstn;
        if (cycle > cycle_limit) begin
            stop_with_failure($sformatf("timeout after %0d cycles, transfers still pending", cycle));
        end
        if (i_axi_register_wr.i_chk.fail_count != 0) begin
            stop_with_failure("a protocol assertion in the bound checker failed");
        end
        // through reset and on the first edge after it
        if (cycle >= 1 && (!rstn || !rstn_q)) begin
            compare_bit("reset m_aw_valid", 1'b0, m_aw_valid);
            compare_bit("reset m_w_valid", 1'b0, m_w_valid);
            compare_bit("reset s_b_valid", 1'b0, s_b_valid);
            compare_bit("reset s_aw_ready", 1'b0, s_aw_ready);
            compare_bit("reset s_w_ready", 1'b0, s_w_ready);
            compare_bit("reset m_b_ready", 1'b0, m_b_ready);
        end
        if (rstn) begin
            if (m_aw_valid && m_aw_ready) begin
                if (aw_got >= aw_exp.size()) begin
                    stop_with_failure("an AW beat came out after the last golden record");
                end else begin
                    compare_aw($sformatf("aw beat %0d", aw_got), aw_exp[aw_got], m_aw);
                    aw_got <= aw_got + 1;
                end
            end
            if (m_w_valid && m_w_ready) begin
                if (w_got >= w_exp.size()) begin
                    stop_with_failure("a W beat came out after the last golden record");
                end else begin
                    compare_w($sformatf("w beat %0d", w_got), w_exp[w_got], m_w);
                    w_got <= w_got + 1;
                    if (m_w.last) begin
                        lasts_seen <= lasts_seen + 1;
                    end
                end
            end
            if (s_b_valid && s_b_ready) begin
                if (b_got >= b_exp.size()) begin
                    stop_with_failure("a B response came out after the last golden record");
                end else begin
                    compare_b($sformatf("b resp %0d", b_got), b_exp[b_got], s_b);
                    b_got <= b_got + 1;
                end
            end
            // simple AW buffer needs a bubble between accepts
            if (s_aw_valid && s_aw_ready && aw_acc_prev) begin
                stop_with_failure("two AW beats were accepted in consecutive cycles");
            end
            aw_acc_prev <= s_aw_valid && s_aw_ready;
            // skid W buffer must take a beat every cycle once streaming
            if (w_hold && s_w_valid) begin
                if (s_w_ready) begin
                    w_phase_beats <= w_phase_beats + 1;
                end else if (w_phase_beats > 0) begin
                    stop_with_failure("W input stalled while m_w_ready was held high");
                end
            end
        end
    end

    initial begin
        load_golden();
        cycle_limit = 6 * (aw_exp.size() + w_exp.size() + b_exp.size()) + 100;
        w_close_at  = w_exp.size() - 6;
        repeat (4) @(posedge clk);
        rstn <= 1'b1;
        while (aw_got < aw_exp.size() || w_got < w_exp.size() || b_got < b_exp.size()) begin
            @(posedge clk);
        end
        // room for any stray extra beat
        repeat (8) @(posedge clk);
        if (w_phase_beats >= 2) begin
            $display("Simulation PASSED");
            $finish;
        end else begin
            stop_with_failure("the W streaming phase accepted fewer than two beats");
        end
    end

endmodule

/* tb/axi_register_wr_golden.txt */
# aw: id addr len size burst prot | w: data strb last | b: id resp
# every field in hex, one record per line, each queue kept in file order
aw 11 00001000 00 2 1 0
w deadbeef f 1
b 11 0
aw 22 00002040 03 2 1 2
w 00000001 f 0
w 00000002 f 0
w 00000003 f 0
w 00000004 f 1
b 22 0
aw 33 0000a00c 00 1 0 1
w 12345678 c 1
b 33 2
aw 44 80000000 01 2 1 3
w cafef00d f 0
w 0badc0de 3 1
b 44 1
aw 55 00003ff0 00 0 1 4
w a5a5a5a5 1 1
b 55 0
aw 66 00004010 02 2 1 5
w 11111111 f 0
w 22222222 f 0
w 33333333 f 1
b 66 3
aw 77 00005020 00 2 1 6
w 5a5a5a5a f 1
b 77 0
aw 88 00006030 01 2 2 7
w fedcba98 f 0
w 76543210 f 1
b 88 0
aw 99 fffffffc 00 2 1 0
w 0f0f0f0f 8 1
b 99 0

/* vlog.f */
design/axi_reg_pkg.sv
design/axi_skid_buffer.sv
design/axi_simple_buffer.sv
design/axi_register_wr.sv
tb/axi_register_wr_chk.sv
tb/tb_axi_register_wr.sv

/* Makefile */
TOP = tb_axi_register_wr

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --top-module axi_register_wr \
		design/axi_reg_pkg.sv design/axi_skid_buffer.sv \
		design/axi_simple_buffer.sv design/axi_register_wr.sv

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f vlog.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "Simulation PASSED"

clean:
	rm -rf obj_dir
